// ==== bpred_fetch_pkg.sv ====
package bpred_fetch_pkg;

   ////////////////////////////////////////////////////////////
   // Fetch-side widths
   ////////////////////////////////////////////////////////////

   // Instruction address
   typedef logic [15:0] pc_t;

   // One bit per fetch slot, set when the slot holds a branch
   typedef logic [3:0] slot_mask_t;

   // Slot number inside a bundle
   typedef logic [1:0] slot_t;

   // Branches in a bundle, 0 to 4
   typedef logic [2:0] branch_count_t;

   ////////////////////////////////////////////////////////////
   // Bundle in, prediction out
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic       valid;
      pc_t        pc;           // Pc of slot 0
      slot_mask_t branch_mask;
      logic       loop_start;   // First branch slot forced taken
   } fetch_bundle_t;

   typedef struct packed {
      logic          valid;
      logic          taken;        // Bundle redirects fetch
      slot_t         taken_slot;   // First predicted-taken slot
      branch_count_t branch_count;
   } bpred_result_t;

endpackage

// ==== bpred_ctr_pkg.sv ====
package bpred_ctr_pkg;

   ////////////////////////////////////////////////////////////
   // Two-bit saturating counter
   ////////////////////////////////////////////////////////////

   // Encoding order matters, the update steps along it
   // Upper bit is the predicted direction
   typedef enum logic [1:0] {
      STRONG_NOT   = 2'b00,
      WEAK_NOT     = 2'b01,
      WEAK_TAKEN   = 2'b10,
      STRONG_TAKEN = 2'b11
   } ctr_state_t;

   ////////////////////////////////////////////////////////////
   // Update from commit or mispredict
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                  valid;
      bpred_fetch_pkg::pc_t  pc;          // The branch's own pc
      bpred_fetch_pkg::slot_t slot;       // Slot the branch was fetched in
      logic                  taken;       // Actual outcome
      logic                  mispredict;  // Two-step move when set
   } bpred_update_t;

endpackage

// ==== slot_index_decode.sv ====
`timescale 1ns/100ps

module slot_index_decode #(
   parameter int FETCH_WIDTH = 4,
   parameter int INDEX_BITS  = 4
) (
   input  bpred_fetch_pkg::pc_t                    fetch_pc,
   input  bpred_ctr_pkg::bpred_update_t            update,
   output logic [FETCH_WIDTH-1:0][INDEX_BITS-1:0]  rd_index,
   output logic [FETCH_WIDTH-1:0]                  wr_en,
   output logic [INDEX_BITS-1:0]                   wr_index
);

   ////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////

   // Each slot table is indexed by its own instruction address
   for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_rd

      // Pc of the instruction sitting in slot s
      bpred_fetch_pkg::pc_t slot_pc;

      assign slot_pc = fetch_pc + bpred_fetch_pkg::pc_t'(s);

      // Low bits only, wraps inside the table
      assign rd_index[s] = slot_pc[INDEX_BITS-1:0];

   end

   ////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////

   // One-hot table select from the update's slot number
   for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_wr

      logic slot_hit;

      assign slot_hit = (update.slot == bpred_fetch_pkg::slot_t'(s));

      // No write without a valid update
      assign wr_en[s] = update.valid && slot_hit;

   end

   // Update carries the branch's own pc, no slot offset needed
   assign wr_index = update.pc[INDEX_BITS-1:0];

endmodule

// ==== slot_counter_table.sv ====
`timescale 1ns/100ps

module slot_counter_table #(
   parameter int INDEX_BITS = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [INDEX_BITS-1:0]      rd_index,
   output bpred_ctr_pkg::ctr_state_t  rd_state,
   input  logic                       wr_en,
   input  logic [INDEX_BITS-1:0]      wr_index,
   input  logic                       wr_taken,
   input  logic                       wr_mispredict
);

   localparam int DEPTH = 2 ** INDEX_BITS;

   ////////////////////////////////////////////////////////////
   // Counter step
   ////////////////////////////////////////////////////////////

   // Moves along the enum order by one or two, clamped at the ends
   function automatic bpred_ctr_pkg::ctr_state_t step_ctr(
      input bpred_ctr_pkg::ctr_state_t cur,
      input logic                      taken,
      input logic                      two_step
   );
      logic [2:0] wide;
      logic [2:0] amount;
      wide   = {1'b0, cur};
      amount = two_step ? 3'd2 : 3'd1;
      if (taken) begin
         // Toward STRONG_TAKEN
         wide = wide + amount;
         if (wide > 3'd3) begin
            wide = 3'd3;
         end
      end else begin
         // Toward STRONG_NOT
         wide = (wide >= amount) ? (wide - amount) : 3'd0;
      end
      return bpred_ctr_pkg::ctr_state_t'(wide[1:0]);
   endfunction

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   bpred_ctr_pkg::ctr_state_t ctr_mem [DEPTH];
   bpred_ctr_pkg::ctr_state_t wr_cur;
   bpred_ctr_pkg::ctr_state_t wr_next;

   // Combinational read, a same-cycle write is not visible yet
   assign rd_state = ctr_mem[rd_index];

   // Read-modify-write of the updated entry
   assign wr_cur  = ctr_mem[wr_index];
   assign wr_next = step_ctr(wr_cur, wr_taken, wr_mispredict);

   // All entries start strongly taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            ctr_mem[i] <= bpred_ctr_pkg::STRONG_TAKEN;
         end
      end else if (wr_en) begin
         ctr_mem[wr_index] <= wr_next;
      end
   end

endmodule

// ==== taken_slot_select.sv ====
`timescale 1ns/100ps

module taken_slot_select #(
   parameter int FETCH_WIDTH = 4
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  bpred_fetch_pkg::fetch_bundle_t                fetch,
   input  bpred_ctr_pkg::ctr_state_t [FETCH_WIDTH-1:0]   rd_state,
   output bpred_fetch_pkg::bpred_result_t                pred
);

   ////////////////////////////////////////////////////////////
   // Slot scan
   ////////////////////////////////////////////////////////////

   bpred_fetch_pkg::branch_count_t branch_count;
   bpred_fetch_pkg::slot_t         first_slot;
   logic                           found;
   bpred_fetch_pkg::bpred_result_t next_pred;

   // Lowest slot wins; loop_start takes the first branch outright
   always_comb begin
      branch_count = '0;
      first_slot   = '0;
      found        = 1'b0;
      for (int s = 0; s < FETCH_WIDTH; s++) begin
         if (fetch.branch_mask[s]) begin
            branch_count = branch_count + 3'd1;
            // Upper counter bit is the taken hint
            if (!found && (fetch.loop_start || rd_state[s][1])) begin
               found      = 1'b1;
               first_slot = bpred_fetch_pkg::slot_t'(s);
            end
         end
      end
   end

   // Slot stays 0 when nothing is taken
   always_comb begin
      next_pred              = '0;
      next_pred.valid        = 1'b1;
      next_pred.taken        = found;
      next_pred.taken_slot   = first_slot;
      next_pred.branch_count = branch_count;
   end

   ////////////////////////////////////////////////////////////
   // Output register, one cycle after the bundle
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pred <= '0;
      end else begin
         // Idle cycles read back as all zeros
         pred <= fetch.valid ? next_pred : '0;
      end
   end

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor #(
   parameter int FETCH_WIDTH = 4,
   parameter int INDEX_BITS  = 4
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  bpred_fetch_pkg::fetch_bundle_t  fetch,
   input  bpred_ctr_pkg::bpred_update_t    update,
   output bpred_fetch_pkg::bpred_result_t  pred
);

   // Decoder to tables
   logic [FETCH_WIDTH-1:0][INDEX_BITS-1:0] rd_index;
   logic [FETCH_WIDTH-1:0]                 wr_en;
   logic [INDEX_BITS-1:0]                  wr_index;

   // Tables to selector
   bpred_ctr_pkg::ctr_state_t [FETCH_WIDTH-1:0] rd_state;

   ////////////////////////////////////////////////////////////
   // Index and write-enable decode
   ////////////////////////////////////////////////////////////

   slot_index_decode #(
      .FETCH_WIDTH (FETCH_WIDTH),
      .INDEX_BITS  (INDEX_BITS)
   ) u_decode (
      .fetch_pc (fetch.pc),
      .update   (update),
      .rd_index (rd_index),
      .wr_en    (wr_en),
      .wr_index (wr_index)
   );

   ////////////////////////////////////////////////////////////
   // One counter table per slot position
   ////////////////////////////////////////////////////////////

   for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_slot
      slot_counter_table #(
         .INDEX_BITS (INDEX_BITS)
      ) u_table (
         .clk           (clk),
         .rst_n         (rst_n),
         .rd_index      (rd_index[s]),
         .rd_state      (rd_state[s]),
         .wr_en         (wr_en[s]),
         .wr_index      (wr_index),
         .wr_taken      (update.taken),
         .wr_mispredict (update.mispredict)
      );
   end

   // First taken slot, branch count, registered result
   taken_slot_select #(
      .FETCH_WIDTH (FETCH_WIDTH)
   ) u_select (
      .clk      (clk),
      .rst_n    (rst_n),
      .fetch    (fetch),
      .rd_state (rd_state),
      .pred     (pred)
   );

endmodule

// ==== branch_predictor_sva.sv ====
`timescale 1ns/100ps

module branch_predictor_sva (
   input logic                           clk,
   input logic                           rst_n,
   input bpred_fetch_pkg::fetch_bundle_t fetch,
   input bpred_fetch_pkg::bpred_result_t pred
);

   ////////////////////////////////////////////////////////////
   // Prediction output rules
   ////////////////////////////////////////////////////////////

   // First cycle out of reset with no bundle leaves pred empty
   a_idle_after_reset: assert property (
      @(posedge clk) ($rose(rst_n) && !fetch.valid) |=> !pred.valid
   ) else $error("pred.valid high after reset release with no bundle");

   // Redirect needs at least one branch
   a_taken_has_branch: assert property (
      @(posedge clk) disable iff (!rst_n) pred.taken |-> (pred.branch_count >= 3'd1)
   ) else $error("pred.taken set with a branch_count of zero");

   // Fixed one-cycle latency, both directions
   a_valid_follows: assert property (
      @(posedge clk) disable iff (!rst_n) fetch.valid |=> pred.valid
   ) else $error("pred.valid missing one cycle after fetch.valid");

   a_idle_follows: assert property (
      @(posedge clk) disable iff (!rst_n) !fetch.valid |=> !pred.valid
   ) else $error("pred.valid high one cycle after an idle fetch");

endmodule

bind branch_predictor branch_predictor_sva u_branch_predictor_sva (
   .clk   (clk),
   .rst_n (rst_n),
   .fetch (fetch),
   .pred  (pred)
);

// ==== tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor;

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 10;
   localparam int DRIVE_DELAY     = 2;
   localparam int MODEL_SLOTS     = 4;
   localparam int MODEL_DEPTH     = 16;
   localparam int RANDOM_CYCLES   = 400;
   // Reset state 17, commit 8, mispredict 4, loop start 5
   localparam int DIRECTED_CYCLES = 17 + 8 + 4 + 5;
   localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;
   localparam logic [31:0] RAND_SEED = 32'hc867_be7f;

   localparam bpred_fetch_pkg::fetch_bundle_t IDLE_BUNDLE = '0;
   localparam bpred_ctr_pkg::bpred_update_t   NO_UPDATE   = '0;

   logic                           clk;
   logic                           rst_n;
   bpred_fetch_pkg::fetch_bundle_t fetch;
   bpred_ctr_pkg::bpred_update_t   update;
   bpred_fetch_pkg::bpred_result_t pred;

   // Model counters per slot table, 0 strong not taken .. 3 strong taken
   int                             model_ctr [MODEL_SLOTS][MODEL_DEPTH];
   bpred_fetch_pkg::bpred_result_t exp_pred;
   int check_count;
   int err_count;
   int test_err_start;
   int tests_failed;
   int cycle_count = 0;

   branch_predictor #(
      .FETCH_WIDTH (4),
      .INDEX_BITS  (4)
   ) u_branch_predictor (
      .clk    (clk),
      .rst_n  (rst_n),
      .fetch  (fetch),
      .update (update),
      .pred   (pred)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   // One or two states toward the outcome, clamped at 0 and 3
   function automatic int step_model(input int cur, input logic taken, input logic mispredict);
      int amount;
      int result;
      amount = mispredict ? 2 : 1;
      result = taken ? cur + amount : cur - amount;
      if (result > 3) result = 3;
      if (result < 0) result = 0;
      return result;
   endfunction

   // Expected pred one cycle after this bundle
   function automatic bpred_fetch_pkg::bpred_result_t predict_model(
      input bpred_fetch_pkg::fetch_bundle_t b
   );
      bpred_fetch_pkg::bpred_result_t r;
      int idx;
      int count;
      r     = '0;
      count = 0;
      if (b.valid) begin
         r.valid = 1'b1;
         for (int s = 0; s < MODEL_SLOTS; s++) begin
            // Slot s holds the instruction at pc + s
            idx = (int'(b.pc) + s) % MODEL_DEPTH;
            if (b.branch_mask[s]) begin
               count++;
               if (!r.taken && (b.loop_start || model_ctr[s][idx] >= 2)) begin
                  r.taken      = 1'b1;
                  r.taken_slot = 2'(s);
               end
            end
         end
         r.branch_count = 3'(count);
      end
      return r;
   endfunction

   function automatic void apply_update_model(input bpred_ctr_pkg::bpred_update_t u);
      int idx;
      idx = int'(u.pc) % MODEL_DEPTH;
      if (u.valid) begin
         model_ctr[u.slot][idx] = step_model(model_ctr[u.slot][idx], u.taken, u.mispredict);
      end
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus and checking
   ////////////////////////////////////////////////////////////

   function automatic bpred_fetch_pkg::fetch_bundle_t make_bundle(
      input bpred_fetch_pkg::pc_t pc, input bpred_fetch_pkg::slot_mask_t mask, input logic loop
   );
      bpred_fetch_pkg::fetch_bundle_t b;
      b.valid       = 1'b1;
      b.pc          = pc;
      b.branch_mask = mask;
      b.loop_start  = loop;
      return b;
   endfunction

   function automatic bpred_ctr_pkg::bpred_update_t make_update(
      input bpred_fetch_pkg::pc_t pc, input bpred_fetch_pkg::slot_t slot,
      input logic taken, input logic mispredict
   );
      bpred_ctr_pkg::bpred_update_t u;
      u.valid      = 1'b1;
      u.pc         = pc;
      u.slot       = slot;
      u.taken      = taken;
      u.mispredict = mispredict;
      return u;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Entered and left at DRIVE_DELAY after a rising edge
   task automatic run_cycle(
      input bpred_fetch_pkg::fetch_bundle_t b, input bpred_ctr_pkg::bpred_update_t u
   );
      fetch    = b;
      update   = u;
      // Bundle reads counters before this cycle's update lands
      exp_pred = predict_model(b);
      apply_update_model(u);
      @(posedge clk);
      #1;
      check_value("pred.valid", 32'(pred.valid), 32'(exp_pred.valid));
      check_value("pred.taken", 32'(pred.taken), 32'(exp_pred.taken));
      check_value("pred.taken_slot", 32'(pred.taken_slot), 32'(exp_pred.taken_slot));
      check_value("pred.branch_count", 32'(pred.branch_count), 32'(exp_pred.branch_count));
      #(DRIVE_DELAY - 1);
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = err_count - test_err_start;
      if (errs != 0) tests_failed++;
      $display("Test %-18s done, %0d mismatches", name, errs);
      test_err_start = err_count;
   endtask

   initial begin
      bpred_fetch_pkg::fetch_bundle_t b;
      bpred_ctr_pkg::bpred_update_t   u;
      logic [31:0] rnd;
      logic [31:0] rnd2;
      rnd            = $urandom(RAND_SEED);
      rst_n          = 1'b0;
      fetch          = IDLE_BUNDLE;
      update         = NO_UPDATE;
      check_count    = 0;
      err_count      = 0;
      test_err_start = 0;
      tests_failed   = 0;
      for (int s = 0; s < MODEL_SLOTS; s++) begin
         for (int i = 0; i < MODEL_DEPTH; i++) model_ctr[s][i] = 3;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      rst_n = 1'b1;

      // All counters strongly taken, lowest branch slot wins
      run_cycle(IDLE_BUNDLE, NO_UPDATE);
      for (int i = 0; i < 16; i++) begin
         rnd = $urandom();
         b   = make_bundle(rnd[15:0], rnd[19:16], 1'b0);
         run_cycle(b, NO_UPDATE);
         check_value("taken after reset", 32'(pred.taken), 32'(b.branch_mask != 4'b0000));
         check_value("count after reset", 32'(pred.branch_count), 32'($countones(b.branch_mask)));
      end
      finish_test("reset_state");

      // Branch at pc 0x0123 in slot 2, bundle starts at 0x0121
      b = make_bundle(16'h0121, 4'b0100, 1'b0);
      u = make_update(16'h0123, 2'd2, 1'b0, 1'b0);
      run_cycle(IDLE_BUNDLE, u);
      run_cycle(IDLE_BUNDLE, u);
      run_cycle(b, NO_UPDATE);
      check_value("taken after two not-taken commits", 32'(pred.taken), 32'd0);
      // Third not-taken commit bottoms out at strong not taken
      run_cycle(IDLE_BUNDLE, u);
      u.taken = 1'b1;
      run_cycle(IDLE_BUNDLE, u);
      run_cycle(b, NO_UPDATE);
      check_value("taken at weak not", 32'(pred.taken), 32'd0);
      run_cycle(IDLE_BUNDLE, u);
      run_cycle(b, NO_UPDATE);
      check_value("taken at weak taken", 32'(pred.taken), 32'd1);
      finish_test("commit_training");

      // Two-step moves, branch at 0x0047 in slot 1
      b = make_bundle(16'h0046, 4'b0010, 1'b0);
      run_cycle(IDLE_BUNDLE, make_update(16'h0047, 2'd1, 1'b0, 1'b1));
      run_cycle(b, NO_UPDATE);
      check_value("taken after mispredict not taken", 32'(pred.taken), 32'd0);
      run_cycle(IDLE_BUNDLE, make_update(16'h0047, 2'd1, 1'b1, 1'b1));
      run_cycle(b, NO_UPDATE);
      check_value("taken after mispredict taken", 32'(pred.taken), 32'd1);
      finish_test("mispredict_step");

      // Slot 0 counter at 0x008A driven to strong not taken
      u = make_update(16'h008A, 2'd0, 1'b0, 1'b1);
      run_cycle(IDLE_BUNDLE, u);
      run_cycle(IDLE_BUNDLE, u);
      run_cycle(make_bundle(16'h008A, 4'b0001, 1'b0), NO_UPDATE);
      check_value("taken at strong not", 32'(pred.taken), 32'd0);
      run_cycle(make_bundle(16'h008A, 4'b0001, 1'b1), NO_UPDATE);
      check_value("loop start taken", 32'(pred.taken), 32'd1);
      // Empty mask, nothing to force
      run_cycle(make_bundle(16'h008A, 4'b0000, 1'b1), NO_UPDATE);
      check_value("empty mask taken", 32'(pred.taken), 32'd0);
      finish_test("loop_start");

      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         rnd          = $urandom();
         rnd2         = $urandom();
         b.valid       = (rnd[1:0] != 2'b00);
         b.pc          = rnd[17:2];
         b.branch_mask = rnd[21:18];
         b.loop_start  = (rnd[24:22] == 3'b000);
         u.valid       = rnd2[0];
         u.slot        = rnd2[2:1];
         u.taken       = rnd2[3];
         u.mispredict  = (rnd2[5:4] == 2'b00);
         u.pc          = rnd2[21:6];
         // Sometimes hit a counter the bundle reads this same cycle
         if (rnd2[23:22] == 2'b00) u.pc = b.pc + 16'(u.slot);
         run_cycle(b, u);
      end
      finish_test("random_mix");

      $display("Summary: %0d checks, %0d errors, %0d of 5 tests failed",
               check_count, err_count, tests_failed);
      if (err_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
bpred_fetch_pkg.sv
bpred_ctr_pkg.sv
slot_index_decode.sv
slot_counter_table.sv
taken_slot_select.sv
branch_predictor.sv
branch_predictor_sva.sv
tb_branch_predictor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the branch predictor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   --top-module tb_branch_predictor \
   -f verilog.f \
   -o sim_branch_predictor

./obj_dir/sim_branch_predictor | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "Simulation reported failures, see $LOG"
   exit 1
fi
echo "Simulation finished without failures"
